// ==== exec_pkg.sv ====
package exec_pkg;

  // datapath width
  localparam int unsigned xlen = 32;

  // alu control
  localparam int unsigned alu_op_w = 4;

  localparam logic [alu_op_w-1:0] alu_add  = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub  = 4'd1;
  localparam logic [alu_op_w-1:0] alu_and  = 4'd2;
  localparam logic [alu_op_w-1:0] alu_or   = 4'd3;
  localparam logic [alu_op_w-1:0] alu_xor  = 4'd4;
  localparam logic [alu_op_w-1:0] alu_slt  = 4'd5;  // risc-v only
  localparam logic [alu_op_w-1:0] alu_pass = 4'd6;  // forwards op2
  localparam logic [alu_op_w-1:0] alu_sltu = 4'd7;  // risc-v only
  localparam logic [alu_op_w-1:0] alu_sll  = 4'd8;
  localparam logic [alu_op_w-1:0] alu_srl  = 4'd9;
  localparam logic [alu_op_w-1:0] alu_sra  = 4'd10;

  // shifter op, low two bits of the alu control
  localparam logic [1:0] sh_sll = 2'd0;
  localparam logic [1:0] sh_srl = 2'd1;
  localparam logic [1:0] sh_sra = 2'd2;
  localparam logic [1:0] sh_ror = 2'd3;  // arm path only

  // operand sources
  localparam logic [1:0] fwd_reg = 2'd0;
  localparam logic [1:0] fwd_mem = 2'd1;
  localparam logic [1:0] fwd_wb  = 2'd2;
  localparam logic [1:0] fwd_imm = 2'd3;  // op2 only

  // branch conditions
  localparam logic [2:0] br_eq     = 3'd0;
  localparam logic [2:0] br_ne     = 3'd1;
  localparam logic [2:0] br_lt     = 3'd2;
  localparam logic [2:0] br_ge     = 3'd3;
  localparam logic [2:0] br_ltu    = 3'd4;
  localparam logic [2:0] br_geu    = 3'd5;
  localparam logic [2:0] br_always = 3'd6;
  localparam logic [2:0] br_never  = 3'd7;

  // positions in the nzcv word
  localparam int unsigned flag_n = 3;
  localparam int unsigned flag_z = 2;
  localparam int unsigned flag_c = 1;
  localparam int unsigned flag_v = 0;

endpackage

// ==== add_sub.sv ====
`timescale 1ns/10ps

module add_sub (
  input  logic [exec_pkg::xlen-1:0] a,
  input  logic [exec_pkg::xlen-1:0] b,
  input  logic                      sub,
  output logic [exec_pkg::xlen-1:0] sum,
  output logic                      carry,
  output logic                      overflow
);

  localparam int unsigned msb = exec_pkg::xlen - 1;

  logic [exec_pkg::xlen-1:0] b_inv;
  logic                      carry_in;
  logic                      carry_out;

  assign b_inv    = sub ? ~b : b;  // two's complement with carry_in
  assign carry_in = sub;

  // single carry chain for both ops
  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_inv} + {{exec_pkg::xlen{1'b0}}, carry_in};

  // borrow after subtract, plain carry after add
  assign carry = carry_out ^ carry_in;

  // operands agree in sign, sum does not
  assign overflow = (~sum[msb] &  a[msb] &  b_inv[msb]) |
                    ( sum[msb] & ~a[msb] & ~b_inv[msb]);

endmodule

// ==== barrel_shift.sv ====
`timescale 1ns/10ps

module barrel_shift (
  input  logic [exec_pkg::xlen-1:0] a,
  input  logic [4:0]                amount,
  input  logic [1:0]                op,
  output logic [exec_pkg::xlen-1:0] q
);

  logic                      fill;
  logic [exec_pkg::xlen-1:0] l16, l8, l4, l2, l1;  // left shift
  logic [exec_pkg::xlen-1:0] r16, r8, r4, r2, r1;  // right shift
  logic [exec_pkg::xlen-1:0] o16, o8, o4, o2, o1;  // rotate right

  assign fill = (op == exec_pkg::sh_sra) ? a[31] : 1'b0;

  // left, zero fill
  assign l16 = amount[4] ? {a[15:0], 16'b0}   : a;
  assign l8  = amount[3] ? {l16[23:0], 8'b0}  : l16;
  assign l4  = amount[2] ? {l8[27:0], 4'b0}   : l8;
  assign l2  = amount[1] ? {l4[29:0], 2'b0}   : l4;
  assign l1  = amount[0] ? {l2[30:0], 1'b0}   : l2;

  // right, sign or zero fill
  assign r16 = amount[4] ? {{16{fill}}, a[31:16]}  : a;
  assign r8  = amount[3] ? {{8{fill}}, r16[31:8]}  : r16;
  assign r4  = amount[2] ? {{4{fill}}, r8[31:4]}   : r8;
  assign r2  = amount[1] ? {{2{fill}}, r4[31:2]}   : r4;
  assign r1  = amount[0] ? {fill, r2[31:1]}        : r2;

  // rotate right, bits wrap to the top
  assign o16 = amount[4] ? {a[15:0], a[31:16]}     : a;
  assign o8  = amount[3] ? {o16[7:0], o16[31:8]}   : o16;
  assign o4  = amount[2] ? {o8[3:0], o8[31:4]}     : o8;
  assign o2  = amount[1] ? {o4[1:0], o4[31:2]}     : o4;
  assign o1  = amount[0] ? {o2[0], o2[31:1]}       : o2;

  always_comb begin
    case (op)
      exec_pkg::sh_sll: q = l1;
      exec_pkg::sh_srl,
      exec_pkg::sh_sra: q = r1;
      exec_pkg::sh_ror: q = o1;
      default:          q = '0;
    endcase
  end

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps

module alu (
  input  logic [exec_pkg::alu_op_w-1:0] alu_control,
  input  logic [exec_pkg::xlen-1:0]     op1,
  input  logic [exec_pkg::xlen-1:0]     op2,
  output logic [exec_pkg::xlen-1:0]     result,
  output logic [3:0]                    flags
);

  logic [exec_pkg::xlen-1:0] add_result;
  logic [exec_pkg::xlen-1:0] shift_result;
  logic [1:0]                shift_op;
  logic                      carry;
  logic                      overflow;
  logic                      lt_signed;

  // odd codes subtract, which slt and sltu rely on
  add_sub add_sub_i (
    .a        (op1),
    .b        (op2),
    .sub      (alu_control[0]),
    .sum      (add_result),
    .carry    (carry),
    .overflow (overflow)
  );

  assign shift_op = alu_control[1:0];

  barrel_shift barrel_shift_i (
    .a      (op1),
    .amount (op2[4:0]),
    .op     (shift_op),
    .q      (shift_result)
  );

  assign lt_signed = add_result[exec_pkg::xlen-1] ^ overflow;

  always_comb begin
    case (alu_control)
      exec_pkg::alu_add,
      exec_pkg::alu_sub:  result = add_result;
      exec_pkg::alu_and:  result = op1 & op2;
      exec_pkg::alu_or:   result = op1 | op2;
      exec_pkg::alu_xor:  result = op1 ^ op2;
      exec_pkg::alu_slt:  result = {{(exec_pkg::xlen-1){1'b0}}, lt_signed};
      exec_pkg::alu_pass: result = op2;  // immediate through
      exec_pkg::alu_sltu: result = {{(exec_pkg::xlen-1){1'b0}}, carry};
      exec_pkg::alu_sll,
      exec_pkg::alu_srl,
      exec_pkg::alu_sra:  result = shift_result;
      default:            result = '0;  // unused codes
    endcase
  end

  always_comb begin
    flags                   = '0;
    flags[exec_pkg::flag_n] = result[exec_pkg::xlen-1];
    flags[exec_pkg::flag_z] = (result == '0);
    flags[exec_pkg::flag_c] = carry;  // from adder for every op
    flags[exec_pkg::flag_v] = overflow;
  end

  // no x may leak from the op select or the shifter into the result
  always_comb begin
    if (!$isunknown({op1, op2}))
      assert final (!$isunknown(result))
        else $error("alu result unknown for known operands");
  end

endmodule

// ==== operand_fwd.sv ====
`timescale 1ns/10ps

module operand_fwd (
  input  logic [1:0]                sel1,
  input  logic [1:0]                sel2,
  input  logic [exec_pkg::xlen-1:0] rs1_data,
  input  logic [exec_pkg::xlen-1:0] rs2_data,
  input  logic [exec_pkg::xlen-1:0] mem_data,
  input  logic [exec_pkg::xlen-1:0] wb_data,
  input  logic [exec_pkg::xlen-1:0] imm,
  output logic [exec_pkg::xlen-1:0] op1,
  output logic [exec_pkg::xlen-1:0] op2
);

  // mem result is the younger one, so decode picks it over wb on a double hit

  always_comb begin
    case (sel1)
      exec_pkg::fwd_reg: op1 = rs1_data;
      exec_pkg::fwd_mem: op1 = mem_data;  // ex/mem result
      exec_pkg::fwd_wb:  op1 = wb_data;   // mem/wb result
      default:           op1 = rs1_data;  // no imm on op1
    endcase
  end

  always_comb begin
    case (sel2)
      exec_pkg::fwd_reg: op2 = rs2_data;
      exec_pkg::fwd_mem: op2 = mem_data;
      exec_pkg::fwd_wb:  op2 = wb_data;
      exec_pkg::fwd_imm: op2 = imm;
      default:           op2 = rs2_data;
    endcase
  end

  // decode must never route the immediate to operand 1
  always_comb begin
    assert final (sel1 !== exec_pkg::fwd_imm)
      else $error("operand 1 selects the immediate");
  end

endmodule

// ==== branch_cond.sv ====
`timescale 1ns/10ps

module branch_cond (
  input  logic [2:0] cond,
  input  logic [3:0] flags,
  output logic       taken
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flags[exec_pkg::flag_n];
  assign z = flags[exec_pkg::flag_z];
  assign c = flags[exec_pkg::flag_c];  // borrow after sub
  assign v = flags[exec_pkg::flag_v];

  // flags come from a sub of the two compared registers
  always_comb begin
    case (cond)
      exec_pkg::br_eq:     taken = z;
      exec_pkg::br_ne:     taken = ~z;
      exec_pkg::br_lt:     taken = n ^ v;   // signed less than
      exec_pkg::br_ge:     taken = ~(n ^ v);
      exec_pkg::br_ltu:    taken = c;       // unsigned less than
      exec_pkg::br_geu:    taken = ~c;
      exec_pkg::br_always: taken = 1'b1;
      exec_pkg::br_never:  taken = 1'b0;
      default:             taken = 1'b0;
    endcase
  end

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/10ps

module exec_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          valid_in,
  input  logic [exec_pkg::alu_op_w-1:0] alu_control,
  input  logic [1:0]                    sel1,
  input  logic [1:0]                    sel2,
  input  logic [2:0]                    cond,
  input  logic [exec_pkg::xlen-1:0]     rs1_data,
  input  logic [exec_pkg::xlen-1:0]     rs2_data,
  input  logic [exec_pkg::xlen-1:0]     mem_data,
  input  logic [exec_pkg::xlen-1:0]     wb_data,
  input  logic [exec_pkg::xlen-1:0]     imm,
  output logic                          valid_out,
  output logic [exec_pkg::xlen-1:0]     result_out,
  output logic [3:0]                    flags_out,
  output logic                          taken_out
);

  logic [exec_pkg::xlen-1:0] op1;
  logic [exec_pkg::xlen-1:0] op2;
  logic [exec_pkg::xlen-1:0] alu_result;
  logic [3:0]                alu_flags;
  logic                      taken;

  operand_fwd operand_fwd_i (
    .sel1     (sel1),
    .sel2     (sel2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .mem_data (mem_data),
    .wb_data  (wb_data),
    .imm      (imm),
    .op1      (op1),
    .op2      (op2)
  );

  alu alu_i (
    .alu_control (alu_control),
    .op1         (op1),
    .op2         (op2),
    .result      (alu_result),
    .flags       (alu_flags)
  );

  branch_cond branch_cond_i (
    .cond  (cond),
    .flags (alu_flags),
    .taken (taken)
  );

  // ex/mem control, follows every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
      taken_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
      taken_out <= taken & valid_in;  // bubbles never branch
    end
  end

  // ex/mem payload, held across bubbles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_out <= '0;
      flags_out  <= '0;
    end else if (valid_in) begin
      result_out <= alu_result;
      flags_out  <= alu_flags;
    end
  end

  // the memory stage only redirects on a valid item
  assert property (@(posedge clk) disable iff (!rst_n) taken_out |-> valid_out)
    else $error("taken_out without valid_out");

endmodule

// ==== tb_exec_stage.sv ====
`timescale 1ns/10ps

module tb_exec_stage;

  localparam int unsigned w = exec_pkg::xlen;

  logic                          clk;
  logic                          rst_n;
  logic                          valid_in;
  logic [exec_pkg::alu_op_w-1:0] alu_control;
  logic [1:0]                    sel1;
  logic [1:0]                    sel2;
  logic [2:0]                    cond;
  logic [w-1:0]                  rs1_data;
  logic [w-1:0]                  rs2_data;
  logic [w-1:0]                  mem_data;
  logic [w-1:0]                  wb_data;
  logic [w-1:0]                  imm;
  logic                          valid_out;
  logic [w-1:0]                  result_out;
  logic [3:0]                    flags_out;
  logic                          taken_out;

  integer       seed;
  string        pend_name;  // item now sitting in the ex/mem register
  logic         exp_valid;
  logic [w-1:0] exp_result;
  logic [3:0]   exp_flags;
  logic         exp_taken;

  logic [w-1:0] edge_vals [4] = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
  logic [3:0]   arith_ops [6] = '{exec_pkg::alu_add, exec_pkg::alu_sub, exec_pkg::alu_and,
                                  exec_pkg::alu_or, exec_pkg::alu_xor, exec_pkg::alu_pass};
  logic [3:0]   cmp_ops   [5] = '{exec_pkg::alu_slt, exec_pkg::alu_sltu, exec_pkg::alu_sll,
                                  exec_pkg::alu_srl, exec_pkg::alu_sra};

  exec_stage dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_in    (valid_in),
    .alu_control (alu_control),
    .sel1        (sel1),
    .sel2        (sel2),
    .cond        (cond),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .mem_data    (mem_data),
    .wb_data     (wb_data),
    .imm         (imm),
    .valid_out   (valid_out),
    .result_out  (result_out),
    .flags_out   (flags_out),
    .taken_out   (taken_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  task automatic fail_run(input string why);
    $display("Checks failed");
    $fatal(1, why);
  endtask

  task automatic check_result(input string name, input logic [w-1:0] exp,
                              input logic [w-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: result expected %h actual %h", name, exp, act);
      fail_run("result mismatch");
    end
  endtask

  task automatic check_flags(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: flags expected %b actual %b", name, exp, act);
      fail_run("flags mismatch");
    end
  endtask

  task automatic check_taken(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: taken expected %b actual %b", name, exp, act);
      fail_run("taken mismatch");
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: valid expected %b actual %b", name, exp, act);
      fail_run("valid mismatch");
    end
  endtask

  task automatic check_all();
    check_valid(pend_name, exp_valid, valid_out);
    check_taken(pend_name, exp_taken, taken_out);
    check_result(pend_name, exp_result, result_out);
    check_flags(pend_name, exp_flags, flags_out);
  endtask

  // reference model of the stage
  task automatic model(input logic [3:0] op, input logic [w-1:0] a, input logic [w-1:0] b,
                       input logic [2:0] cc, output logic [w-1:0] res,
                       output logic [3:0] flg, output logic tk);
    logic [w:0]   wide;
    logic [w-1:0] sum;
    logic         c;
    logic         v;
    if (op[0]) begin
      sum = a - b;
      c   = a < b;  // borrow
      v   = (a[w-1] != b[w-1]) && (sum[w-1] != a[w-1]);
    end else begin
      wide = {1'b0, a} + {1'b0, b};
      sum  = wide[w-1:0];
      c    = wide[w];
      v    = (a[w-1] == b[w-1]) && (sum[w-1] != a[w-1]);
    end
    case (op)
      exec_pkg::alu_add, exec_pkg::alu_sub: res = sum;
      exec_pkg::alu_and:  res = a & b;
      exec_pkg::alu_or:   res = a | b;
      exec_pkg::alu_xor:  res = a ^ b;
      exec_pkg::alu_slt:  res = {{(w-1){1'b0}}, ($signed(a) < $signed(b))};
      exec_pkg::alu_pass: res = b;
      exec_pkg::alu_sltu: res = {{(w-1){1'b0}}, (a < b)};
      exec_pkg::alu_sll:  res = a << b[4:0];
      exec_pkg::alu_srl:  res = a >> b[4:0];
      exec_pkg::alu_sra:  res = $unsigned($signed(a) >>> b[4:0]);
      default:            res = '0;
    endcase
    flg                   = '0;
    flg[exec_pkg::flag_n] = res[w-1];
    flg[exec_pkg::flag_z] = (res == '0);
    flg[exec_pkg::flag_c] = c;
    flg[exec_pkg::flag_v] = v;
    case (cc)
      exec_pkg::br_eq:     tk = flg[exec_pkg::flag_z];
      exec_pkg::br_ne:     tk = !flg[exec_pkg::flag_z];
      exec_pkg::br_lt:     tk = flg[exec_pkg::flag_n] != flg[exec_pkg::flag_v];
      exec_pkg::br_ge:     tk = flg[exec_pkg::flag_n] == flg[exec_pkg::flag_v];
      exec_pkg::br_ltu:    tk = flg[exec_pkg::flag_c];
      exec_pkg::br_geu:    tk = !flg[exec_pkg::flag_c];
      exec_pkg::br_always: tk = 1'b1;
      default:             tk = 1'b0;
    endcase
  endtask

  // drives on a falling edge and checks one edge later
  task automatic drive(input string name, input logic vld, input logic [3:0] op,
                       input logic [1:0] s1, input logic [1:0] s2, input logic [2:0] cc,
                       input logic [w-1:0] r1, input logic [w-1:0] r2,
                       input logic [w-1:0] m, input logic [w-1:0] wbv,
                       input logic [w-1:0] im);
    logic [w-1:0] a;
    logic [w-1:0] b;
    logic [w-1:0] res;
    logic [3:0]   flg;
    logic         tk;
    valid_in    = vld;
    alu_control = op;
    sel1        = s1;
    sel2        = s2;
    cond        = cc;
    rs1_data    = r1;
    rs2_data    = r2;
    mem_data    = m;
    wb_data     = wbv;
    imm         = im;
    case (s1)
      exec_pkg::fwd_mem: a = m;
      exec_pkg::fwd_wb:  a = wbv;
      default:           a = r1;
    endcase
    case (s2)
      exec_pkg::fwd_mem: b = m;
      exec_pkg::fwd_wb:  b = wbv;
      exec_pkg::fwd_imm: b = im;
      default:           b = r2;
    endcase
    model(op, a, b, cc, res, flg, tk);
    pend_name = name;
    exp_valid = vld;
    exp_taken = vld & tk;
    if (vld) begin
      exp_result = res;  // payload holds across bubbles
      exp_flags  = flg;
    end
    @(negedge clk);
    check_all();
  endtask

  function automatic logic [w-1:0] rand_word();
    logic [w-1:0] pick;
    pick = $random(seed);
    if (pick[2:0] == 3'd0)
      return edge_vals[pick[4:3]];
    return $random(seed);
  endfunction

  task automatic drive_random(input string name, input logic vld, input logic [3:0] op,
                              input logic [2:0] cc);
    drive(name, vld, op, 2'($unsigned($random(seed)) % 3), 2'($random(seed)), cc,
          rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      fail_run("reset timeout");
    end
    @(negedge clk);
  endtask

  initial begin
    logic [w-1:0] a;
    logic [w-1:0] b;
    logic [w-1:0] tag [5];
    int           sent;
    seed        = 32'h369d_c220;
    valid_in    = 1'b0;
    alu_control = '0;
    sel1        = exec_pkg::fwd_reg;
    sel2        = exec_pkg::fwd_reg;
    cond        = exec_pkg::br_never;
    rs1_data    = '0;
    rs2_data    = '0;
    mem_data    = '0;
    wb_data     = '0;
    imm         = '0;
    pend_name   = "reset";
    exp_valid   = 1'b0;
    exp_taken   = 1'b0;
    exp_result  = '0;
    exp_flags   = '0;

    wait_reset();
    check_all();
    repeat (4) drive_random("idle", 1'b0, exec_pkg::alu_add, exec_pkg::br_always);

    for (int i = 0; i < 300; i++)
      drive_random("arith", 1'b1, arith_ops[$unsigned($random(seed)) % 6], 3'($random(seed)));

    for (int i = 0; i < 300; i++) begin
      a = rand_word();
      b = rand_word();
      if (i % 10 == 0) b[4:0] = 5'd0;
      if (i % 10 == 1) b[4:0] = 5'd31;
      drive("cmp_shift", 1'b1, cmp_ops[$unsigned($random(seed)) % 5], exec_pkg::fwd_reg,
            exec_pkg::fwd_reg, 3'($random(seed)), a, b, rand_word(), rand_word(), rand_word());
    end

    // top bits tag each source so a wrong pick cannot alias
    for (int s1 = 0; s1 < 3; s1++) begin
      for (int s2 = 0; s2 < 4; s2++) begin
        for (int k = 0; k < 5; k++) begin
          tag[k]        = $random(seed);
          tag[k][31:29] = 3'(k);
        end
        drive("fwd_pass", 1'b1, exec_pkg::alu_pass, 2'(s1), 2'(s2), exec_pkg::br_never,
              tag[0], tag[1], tag[2], tag[3], tag[4]);
        drive("fwd_add", 1'b1, exec_pkg::alu_add, 2'(s1), 2'(s2), exec_pkg::br_never,
              tag[0], tag[1], tag[2], tag[3], tag[4]);
      end
    end

    for (int i = 0; i < 40; i++) begin
      a = rand_word();
      b = (i % 4 == 0) ? a : rand_word();
      for (int cc = 0; cc < 8; cc++)
        drive("branch", 1'b1, exec_pkg::alu_sub, exec_pkg::fwd_reg, exec_pkg::fwd_reg,
              3'(cc), a, b, rand_word(), rand_word(), rand_word());
      drive_random("branch_bubble", 1'b0, exec_pkg::alu_sub, exec_pkg::br_always);
    end

    sent = 0;
    while (sent < 2000) begin
      if ($unsigned($random(seed)) % 4 == 0) begin
        drive_random("stream_bubble", 1'b0, 4'($random(seed)), 3'($random(seed)));
      end else begin
        drive_random("stream", 1'b1, 4'($random(seed)), 3'($random(seed)));
        sent++;
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== flist.f ====
exec_pkg.sv
add_sub.sv
barrel_shift.sv
alu.sv
operand_fwd.sv
branch_cond.sv
exec_stage.sv
tb_exec_stage.sv

// ==== Makefile ====
# Verilator build and run for the execute stage

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_exec_stage
RTL_TOP    ?= exec_stage
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= All checks passed

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
